/* source/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Data path and address widths
`define CACHE_WORD_W    32
`define CACHE_ADR_W     32

// Geometry
`define CACHE_SETS      128
`define CACHE_INDEX_W   7
`define CACHE_WAYS      4
`define CACHE_WAY_W     2
`define CACHE_WORDS     4
`define CACHE_OFS_W     2
`define CACHE_TAG_W     21
`define CACHE_AGE_MAX   3

// Address split: tag | index | word offset | byte offset
`define CACHE_OFS_LSB   2
`define CACHE_INDEX_LSB 4
`define CACHE_TAG_LSB   11

`endif

/* source/cache_pkg.sv */
`include "cache_defs.svh"

package cache_pkg;

    typedef logic [`CACHE_ADR_W-1:0]   adr_t;
    typedef logic [`CACHE_WORD_W-1:0]  word_t;
    typedef logic [`CACHE_TAG_W-1:0]   tag_t;
    typedef logic [`CACHE_INDEX_W-1:0] index_t;
    typedef logic [`CACHE_WAY_W-1:0]   way_t;
    typedef logic [`CACHE_OFS_W-1:0]   ofs_t;

    // One way of a tag RAM entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // Saturating age, larger means older
    typedef logic [1:0] age_t;

    typedef enum logic [1:0] {
        LOAD_WORD  = 2'd0,
        LOAD_BYTE  = 2'd1,
        LOAD_UBYTE = 2'd2
    } load_kind_t;

endpackage

/* source/set_ram.sv */
`timescale 1ns/100ps

module set_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 128
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] adr,
    input  entry_t                   wdata,
    output entry_t                   rdata
);

    entry_t mem [DEPTH];

    // Read is registered and returns the old entry on a write
    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[adr] <= wdata;
        end
        rdata <= mem[adr];
    end

endmodule

/* source/tag_store.sv */
`timescale 1ns/100ps
`include "cache_defs.svh"

module tag_store (
    input  logic              clk,
    input  logic              rst,
    input  cache_pkg::index_t index,
    input  cache_pkg::tag_t   tag,
    input  logic              lookup,
    input  logic              update,
    output logic              ready,
    output logic              hit,
    output cache_pkg::way_t   way
);

    logic                  sweep_on;
    cache_pkg::index_t     sweep_idx;
    cache_pkg::index_t     ram_adr;
    logic                  armed;
    cache_pkg::tag_entry_t tag_rd [`CACHE_WAYS];
    cache_pkg::tag_entry_t tag_wr;
    cache_pkg::age_t       age_rd [`CACHE_WAYS];
    cache_pkg::age_t       age_wr [`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0] match;
    cache_pkg::way_t       hit_way;
    cache_pkg::way_t       victim;

    // Sweep one set per cycle after reset
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            sweep_on  <= 1'b1;
            sweep_idx <= '0;
        end
        else if (sweep_on)
        begin
            sweep_idx <= sweep_idx + 1'b1;
            if (sweep_idx == cache_pkg::index_t'(`CACHE_SETS - 1))
                sweep_on <= 1'b0;
        end
    end

    // Hit is only reported for a lookup still in flight
    always_ff @(posedge clk)
    begin
        if (rst)
            armed <= 1'b0;
        else if (lookup)
            armed <= 1'b1;
        else if (update)
            armed <= 1'b0;
    end

    assign ready   = ~sweep_on;
    assign ram_adr = sweep_on ? sweep_idx : index;
    assign tag_wr  = sweep_on ? cache_pkg::tag_entry_t'('0) :
                                cache_pkg::tag_entry_t'{valid: 1'b1, tag: tag};

    for (genvar w = 0; w < `CACHE_WAYS; w++)
    begin : g_way
        assign match[w]  = tag_rd[w].valid && (tag_rd[w].tag == tag);
        assign age_wr[w] = (sweep_on || way == w) ? '0 :
                           (age_rd[w] == cache_pkg::age_t'(`CACHE_AGE_MAX)) ? age_rd[w] :
                           age_rd[w] + 1'b1;

        set_ram #(.entry_t(cache_pkg::tag_entry_t), .DEPTH(`CACHE_SETS)) tag_ram_inst (
            .clk   (clk),
            .we    (sweep_on || (update && way == w)),
            .adr   (ram_adr),
            .wdata (tag_wr),
            .rdata (tag_rd[w])
        );

        set_ram #(.entry_t(cache_pkg::age_t), .DEPTH(`CACHE_SETS)) age_ram_inst (
            .clk   (clk),
            .we    (sweep_on || update),
            .adr   (ram_adr),
            .wdata (age_wr[w]),
            .rdata (age_rd[w])
        );
    end

    // First matching way, and first way holding the largest age
    always_comb
    begin
        hit_way = '0;
        victim  = '0;
        for (int w = `CACHE_WAYS - 1; w >= 0; w--)
            if (match[w])
                hit_way = cache_pkg::way_t'(w);
        for (int w = 1; w < `CACHE_WAYS; w++)
            if (age_rd[w] > age_rd[victim])
                victim = cache_pkg::way_t'(w);
    end

    assign hit = armed && (|match);
    assign way = (|match) ? hit_way : victim;

endmodule

/* source/data_store.sv */
`timescale 1ns/100ps
`include "cache_defs.svh"

module data_store (
    input  logic                  clk,
    input  cache_pkg::index_t     index,
    input  cache_pkg::way_t       way,
    input  cache_pkg::ofs_t       ofs,
    input  logic [1:0]            byte_sel,
    input  logic                  we,
    input  cache_pkg::word_t      wdata,
    input  cache_pkg::word_t      fill_word,
    input  cache_pkg::load_kind_t kind,
    output cache_pkg::word_t      rdata
);

    localparam int DEPTH = `CACHE_SETS * `CACHE_WORDS;

    cache_pkg::word_t way_rd [`CACHE_WAYS];
    cache_pkg::word_t word_sel;
    logic [7:0]       byte_val;

    // One word RAM per way, addressed by set and word offset
    for (genvar w = 0; w < `CACHE_WAYS; w++)
    begin : g_way
        set_ram #(.entry_t(cache_pkg::word_t), .DEPTH(DEPTH)) word_ram_inst (
            .clk   (clk),
            .we    (we && way == w),
            .adr   ({index, ofs}),
            .wdata (wdata),
            .rdata (way_rd[w])
        );
    end

    // A refill ack hands the memory word straight through
    assign word_sel = we ? fill_word : way_rd[way];
    assign byte_val = word_sel[{byte_sel, 3'b000} +: 8];

    always_comb
    begin
        case (kind)
            cache_pkg::LOAD_BYTE:
                rdata = {{(`CACHE_WORD_W - 8){byte_val[7]}}, byte_val};
            cache_pkg::LOAD_UBYTE:
                rdata = {{(`CACHE_WORD_W - 8){1'b0}}, byte_val};
            default:
                rdata = word_sel;
        endcase
    end

endmodule

/* source/cache_fsm.sv */
`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cpu_req,
    input  cache_pkg::adr_t       cpu_adr,
    input  logic                  cpu_we,
    input  cache_pkg::word_t      cpu_wdata,
    input  logic                  cpu_lb,
    input  logic                  cpu_lbu,
    input  logic                  ready,
    input  logic                  hit,
    output logic                  cpu_ack,
    output logic                  mem_req,
    output cache_pkg::adr_t       mem_adr,
    input  logic                  mem_ack,
    input  cache_pkg::word_t      mem_rdata,
    output cache_pkg::index_t     index,
    output cache_pkg::tag_t       tag,
    output cache_pkg::ofs_t       ofs,
    output logic [1:0]            byte_sel,
    output cache_pkg::load_kind_t kind,
    output logic                  lookup,
    output logic                  update,
    output logic                  data_we,
    output cache_pkg::word_t      wdata
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_HIT,
        S_FILL_FIRST,
        S_FILL_REST
    } state_t;

    state_t                state;
    state_t                state_nxt;
    cache_pkg::adr_t       req_adr;
    logic                  req_we;
    cache_pkg::word_t      req_wdata;
    cache_pkg::load_kind_t req_kind;
    cache_pkg::ofs_t       cnt;
    cache_pkg::ofs_t       cnt_inc;
    cache_pkg::ofs_t       req_ofs;
    logic                  send;
    logic                  take;
    logic                  fill_ack;
    logic                  is_last;

    assign take     = (state == S_IDLE) && cpu_req && ready;
    assign fill_ack = ((state == S_FILL_FIRST) || (state == S_FILL_REST)) && mem_ack;
    assign req_ofs  = req_adr[`CACHE_INDEX_LSB-1:`CACHE_OFS_LSB];
    assign cnt_inc  = cnt + 1'b1;
    // Fourth word when the counter is about to wrap to the critical offset
    assign is_last  = (cnt_inc == req_ofs);

    always_comb
    begin
        state_nxt = state;
        case (state)
            S_IDLE:
                if (take)
                    state_nxt = S_LOOKUP;
            S_LOOKUP:
                state_nxt = hit ? S_HIT : S_FILL_FIRST;
            S_HIT:
                state_nxt = S_IDLE;
            S_FILL_FIRST:
                if (mem_ack)
                    state_nxt = S_FILL_REST;
            S_FILL_REST:
                if (mem_ack && is_last)
                    state_nxt = S_IDLE;
            default:
                state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            cnt   <= '0;
            send  <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            if (take)
                cnt <= cpu_adr[`CACHE_INDEX_LSB-1:`CACHE_OFS_LSB];
            else if (fill_ack)
                cnt <= cnt_inc;
            // Next word goes out one cycle after each ack
            if (fill_ack && !((state == S_FILL_REST) && is_last))
                send <= 1'b1;
            else if (state == S_FILL_REST)
                send <= 1'b0;
        end
    end

    // Request latch
    always_ff @(posedge clk)
    begin
        if (take)
        begin
            req_adr   <= cpu_adr;
            req_we    <= cpu_we;
            req_wdata <= cpu_wdata;
            if (cpu_lb)
                req_kind <= cache_pkg::LOAD_BYTE;
            else if (cpu_lbu)
                req_kind <= cache_pkg::LOAD_UBYTE;
            else
                req_kind <= cache_pkg::LOAD_WORD;
        end
    end

    // Arrays follow the CPU address while idle
    assign index = (state == S_IDLE) ? cpu_adr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB]
                                     : req_adr[`CACHE_TAG_LSB-1:`CACHE_INDEX_LSB];
    assign tag   = (state == S_IDLE) ? cpu_adr[`CACHE_ADR_W-1:`CACHE_TAG_LSB]
                                     : req_adr[`CACHE_ADR_W-1:`CACHE_TAG_LSB];
    assign ofs   = (state == S_IDLE) ? cpu_adr[`CACHE_INDEX_LSB-1:`CACHE_OFS_LSB] : cnt;

    assign byte_sel = req_adr[`CACHE_OFS_LSB-1:0];
    assign kind     = req_kind;
    assign lookup   = take;

    assign cpu_ack = (state == S_HIT) || ((state == S_FILL_FIRST) && mem_ack);
    assign update  = cpu_ack;
    assign data_we = ((state == S_HIT) && req_we) || fill_ack;

    // CPU data replaces the word on a store hit or the critical word of a store miss
    assign wdata = (req_we && ((state == S_HIT) || (state == S_FILL_FIRST))) ? req_wdata
                                                                             : mem_rdata;

    assign mem_req = ((state == S_LOOKUP) && !hit) || ((state == S_FILL_REST) && send);
    assign mem_adr = {req_adr[`CACHE_ADR_W-1:`CACHE_INDEX_LSB], cnt, 2'b00};

endmodule

/* source/cache_top.sv */
`timescale 1ns/100ps

module cache_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             cpu_req,
    input  cache_pkg::adr_t  cpu_adr,
    input  logic             cpu_we,
    input  cache_pkg::word_t cpu_wdata,
    input  logic             cpu_lb,
    input  logic             cpu_lbu,
    output logic             cpu_ack,
    output cache_pkg::word_t cpu_rdata,
    output logic             mem_req,
    output cache_pkg::adr_t  mem_adr,
    input  logic             mem_ack,
    input  cache_pkg::word_t mem_rdata
);

    cache_pkg::index_t     index;
    cache_pkg::tag_t       tag;
    cache_pkg::ofs_t       ofs;
    logic [1:0]            byte_sel;
    cache_pkg::load_kind_t kind;
    logic                  lookup;
    logic                  update;
    logic                  data_we;
    cache_pkg::word_t      wdata;
    logic                  ready;
    logic                  hit;
    cache_pkg::way_t       way;

    cache_fsm cache_fsm_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_adr   (cpu_adr),
        .cpu_we    (cpu_we),
        .cpu_wdata (cpu_wdata),
        .cpu_lb    (cpu_lb),
        .cpu_lbu   (cpu_lbu),
        .ready     (ready),
        .hit       (hit),
        .cpu_ack   (cpu_ack),
        .mem_req   (mem_req),
        .mem_adr   (mem_adr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .index     (index),
        .tag       (tag),
        .ofs       (ofs),
        .byte_sel  (byte_sel),
        .kind      (kind),
        .lookup    (lookup),
        .update    (update),
        .data_we   (data_we),
        .wdata     (wdata)
    );

    tag_store tag_store_inst (
        .clk    (clk),
        .rst    (rst),
        .index  (index),
        .tag    (tag),
        .lookup (lookup),
        .update (update),
        .ready  (ready),
        .hit    (hit),
        .way    (way)
    );

    // Refill words come straight from the memory port
    data_store data_store_inst (
        .clk       (clk),
        .index     (index),
        .way       (way),
        .ofs       (ofs),
        .byte_sel  (byte_sel),
        .we        (data_we),
        .wdata     (wdata),
        .fill_word (mem_rdata),
        .kind      (kind),
        .rdata     (cpu_rdata)
    );

endmodule

/* bench/cache_checker.sv */
`timescale 1ns/100ps

module cache_checker (
    input logic            clk,
    input logic            rst,
    input logic            cpu_ack,
    input logic            mem_req,
    input cache_pkg::adr_t mem_adr,
    input logic            mem_ack
);

    logic ack_fail   = 1'b0;
    logic req_fail   = 1'b0;
    logic hold_fail  = 1'b0;
    logic rst_fail   = 1'b0;
    logic any_fail;
    logic wait_reply;

    assign any_fail = ack_fail | req_fail | hold_fail | rst_fail;

    // High from a memory request until its reply
    always_ff @(posedge clk)
    begin
        if (rst)
            wait_reply <= 1'b0;
        else if (mem_req)
            wait_reply <= 1'b1;
        else if (mem_ack)
            wait_reply <= 1'b0;
    end

    // Both strobes are single-cycle pulses
    ack_single: assert property (@(posedge clk) disable iff (rst) cpu_ack |=> !cpu_ack)
    else
    begin
        ack_fail = 1'b1;
        $error("cpu_ack stayed high for two cycles");
    end

    req_single: assert property (@(posedge clk) disable iff (rst) mem_req |=> !mem_req)
    else
    begin
        req_fail = 1'b1;
        $error("mem_req stayed high for two cycles");
    end

    // Memory address holds until the reply arrives
    req_held: assert property (@(posedge clk) disable iff (rst) wait_reply |-> $stable(mem_adr))
    else
    begin
        hold_fail = 1'b1;
        $error("mem_adr changed before the memory reply");
    end

    // Outputs settle one edge into reset
    quiet_in_reset: assert property (@(posedge clk) rst |=> !cpu_ack && !mem_req)
    else
    begin
        rst_fail = 1'b1;
        $error("cpu_ack or mem_req seen while rst is high");
    end

endmodule

bind cache_top cache_checker cache_checker_inst (
    .clk     (clk),
    .rst     (rst),
    .cpu_ack (cpu_ack),
    .mem_req (mem_req),
    .mem_adr (mem_adr),
    .mem_ack (mem_ack)
);

/* bench/cache_tb.sv */
`timescale 1ns/100ps
`include "cache_defs.svh"

module cache_tb;

    typedef enum logic [1:0] {OP_LW, OP_LB, OP_LBU, OP_SW} op_t;

    localparam int ACK_LIMIT    = 64;
    localparam int REFILL_LIMIT = 64;
    localparam int READY_LIMIT  = 400;

    logic             clk = 1'b0;
    logic             rst;
    logic             cpu_req;
    cache_pkg::adr_t  cpu_adr;
    logic             cpu_we;
    cache_pkg::word_t cpu_wdata;
    logic             cpu_lb;
    logic             cpu_lbu;
    logic             cpu_ack;
    cache_pkg::word_t cpu_rdata;
    logic             mem_req;
    cache_pkg::adr_t  mem_adr;
    logic             mem_ack = 1'b0;
    cache_pkg::word_t mem_rdata = '0;

    // Memory model
    integer           seed = 32'he16a546d;
    int               delay;
    logic             pend = 1'b0;
    int               pend_wait;
    cache_pkg::adr_t  pend_adr;
    int               req_total = 0;
    int               ack_total = 0;
    cache_pkg::adr_t  adr_log [$];

    // Operation table
    string            row_name [$];
    op_t              row_op [$];
    cache_pkg::adr_t  row_adr [$];
    cache_pkg::word_t row_wdata [$];
    logic             row_miss [$];
    cache_pkg::word_t row_exp [$];

    always #2 clk = ~clk;

    cache_top cache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_adr   (cpu_adr),
        .cpu_we    (cpu_we),
        .cpu_wdata (cpu_wdata),
        .cpu_lb    (cpu_lb),
        .cpu_lbu   (cpu_lbu),
        .cpu_ack   (cpu_ack),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_adr   (mem_adr),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    // Memory contents: word address mixed with a fixed pattern
    function automatic cache_pkg::word_t mem_word(input cache_pkg::adr_t adr);
        return {2'b00, adr[31:2]} ^ 32'hc3a5_7e81;
    endfunction

    task automatic abort_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped after an error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // Reply 1 to 4 cycles after each request
    always @(posedge clk)
    begin
        mem_ack <= 1'b0;
        if (mem_req)
        begin
            assert (!pend)
            else
            begin
                $display("Memory request issued while a reply was still pending");
                abort_run();
            end
            req_total <= req_total + 1;
            adr_log.push_back(mem_adr);
            delay = $unsigned($random(seed)) % 4;
            if (delay == 0)
            begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem_word(mem_adr);
                ack_total <= ack_total + 1;
            end
            else
            begin
                pend      <= 1'b1;
                pend_adr  <= mem_adr;
                pend_wait <= delay - 1;
            end
        end
        else if (pend)
        begin
            if (pend_wait == 0)
            begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem_word(pend_adr);
                ack_total <= ack_total + 1;
                pend      <= 1'b0;
            end
            else
                pend_wait <= pend_wait - 1;
        end
    end

    task automatic add_row(input string name, input op_t op, input cache_pkg::adr_t adr,
                           input cache_pkg::word_t wdata, input logic miss);
        row_name.push_back(name);
        row_op.push_back(op);
        row_adr.push_back(adr);
        row_wdata.push_back(wdata);
        row_miss.push_back(miss);
    endtask

    task automatic build_table();
        // Cold line, then another word of it
        add_row("cold_load", OP_LW, 32'h0000_0108, '0, 1'b1);
        add_row("line_hit", OP_LW, 32'h0000_0100, '0, 1'b0);
        add_row("lb_byte0", OP_LB, 32'h0000_0104, '0, 1'b0);
        add_row("lb_byte1", OP_LB, 32'h0000_0105, '0, 1'b0);
        add_row("lb_byte2", OP_LB, 32'h0000_0106, '0, 1'b0);
        add_row("lb_byte3", OP_LB, 32'h0000_0107, '0, 1'b0);
        add_row("lbu_byte0", OP_LBU, 32'h0000_0104, '0, 1'b0);
        add_row("lbu_byte1", OP_LBU, 32'h0000_0105, '0, 1'b0);
        add_row("lbu_byte2", OP_LBU, 32'h0000_0106, '0, 1'b0);
        add_row("lbu_byte3", OP_LBU, 32'h0000_0107, '0, 1'b0);
        add_row("store_hit", OP_SW, 32'h0000_010c, 32'h8765_4321, 1'b0);
        add_row("load_stored", OP_LW, 32'h0000_010c, '0, 1'b0);
        add_row("lb_stored", OP_LB, 32'h0000_010f, '0, 1'b0);
        add_row("load_neighbor", OP_LW, 32'h0000_0108, '0, 1'b0);
        // Write-allocate on a store miss
        add_row("store_miss", OP_SW, 32'h0000_0204, 32'hdead_beef, 1'b1);
        add_row("load_alloc", OP_LW, 32'h0000_0204, '0, 1'b0);
        add_row("load_alloc_nb", OP_LW, 32'h0000_020c, '0, 1'b0);
        // Five tags in set 0x30
        add_row("fill_a", OP_LW, 32'h0000_0308, '0, 1'b1);
        add_row("fill_b", OP_LW, 32'h0000_0b04, '0, 1'b1);
        add_row("fill_c", OP_LW, 32'h0000_130c, '0, 1'b1);
        add_row("fill_d", OP_LW, 32'h0000_1b00, '0, 1'b1);
        add_row("fill_e", OP_LW, 32'h0000_2304, '0, 1'b1);
        add_row("reload_a", OP_LW, 32'h0000_0300, '0, 1'b1);
        add_row("hit_d", OP_LW, 32'h0000_1b08, '0, 1'b0);
    endtask

    task automatic expect_rows();
        cache_pkg::word_t stored [cache_pkg::adr_t];
        cache_pkg::adr_t  wa;
        cache_pkg::adr_t  line;
        cache_pkg::word_t w;
        logic [7:0]       b;

        for (int i = 0; i < row_adr.size(); i++)
        begin
            wa   = {row_adr[i][31:2], 2'b00};
            line = {row_adr[i][31:4], 4'b0000};
            // A miss means the line had left the cache, taking its stores along
            if (row_miss[i])
                for (int k = 0; k < `CACHE_WORDS; k++)
                    stored.delete(line + cache_pkg::adr_t'(4 * k));
            if (row_op[i] == OP_SW)
                stored[wa] = row_wdata[i];
            w = stored.exists(wa) ? stored[wa] : mem_word(wa);
            b = 8'(w >> (8 * row_adr[i][1:0]));
            case (row_op[i])
                OP_LB:   row_exp.push_back({{24{b[7]}}, b});
                OP_LBU:  row_exp.push_back({24'b0, b});
                default: row_exp.push_back(w);
            endcase
        end
    endtask

    task automatic wait_ready();
        int cycles;

        cycles = 0;
        @(negedge clk);
        while (!cache_top_inst.ready && cycles < READY_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (cache_top_inst.ready)
        else
        begin
            $display("Timeout waiting for the reset sweep to finish");
            abort_run();
        end
    endtask

    task automatic run_row(input int i);
        int               cycles;
        int               start_req;
        int               start_ack;
        logic             missed;
        cache_pkg::word_t got;
        cache_pkg::ofs_t  ofs;

        start_req = req_total;
        start_ack = ack_total;
        @(posedge clk);
        cpu_req   <= 1'b1;
        cpu_adr   <= row_adr[i];
        cpu_we    <= (row_op[i] == OP_SW);
        cpu_wdata <= row_wdata[i];
        cpu_lb    <= (row_op[i] == OP_LB);
        cpu_lbu   <= (row_op[i] == OP_LBU);

        cycles = 0;
        @(negedge clk);
        while (!cpu_ack && cycles < ACK_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        assert (cpu_ack)
        else
        begin
            $display("Timeout waiting for cpu_ack in row %s", row_name[i]);
            abort_run();
        end
        got    = cpu_rdata;
        missed = (req_total != start_req);

        @(posedge clk);
        cpu_req <= 1'b0;
        cpu_we  <= 1'b0;
        cpu_lb  <= 1'b0;
        cpu_lbu <= 1'b0;
        @(negedge clk);

        check_value({row_name[i], " miss"}, {31'b0, row_miss[i]}, {31'b0, missed});
        if (row_op[i] != OP_SW)
            check_value(row_name[i], row_exp[i], got);

        if (missed)
        begin
            cycles = 0;
            while (ack_total - start_ack < `CACHE_WORDS && cycles < REFILL_LIMIT)
            begin
                @(negedge clk);
                cycles++;
            end
            assert (ack_total - start_ack == `CACHE_WORDS)
            else
            begin
                $display("Timeout waiting for the line refill in row %s", row_name[i]);
                abort_run();
            end
            check_value({row_name[i], " mem_req count"}, `CACHE_WORDS, req_total - start_req);
            // Critical word first, then wrap order
            for (int k = 0; k < `CACHE_WORDS; k++)
            begin
                ofs = row_adr[i][3:2] + cache_pkg::ofs_t'(k);
                check_value({row_name[i], " refill address"},
                            {row_adr[i][31:4], ofs, 2'b00}, adr_log[start_req + k]);
            end
        end
        else
            check_value({row_name[i], " mem_req count"}, 0, req_total - start_req);
    endtask

    initial
    begin
        rst       = 1'b1;
        cpu_req   = 1'b0;
        cpu_adr   = '0;
        cpu_we    = 1'b0;
        cpu_wdata = '0;
        cpu_lb    = 1'b0;
        cpu_lbu   = 1'b0;
        build_table();
        expect_rows();
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        wait_ready();
        for (int i = 0; i < row_name.size(); i++)
            run_row(i);
        if (!cache_top_inst.cache_checker_inst.any_fail)
        begin
            $display("Result: PASSED");
            $finish;
        end
        else
        begin
            $display("A bound assertion on the cache ports failed during the run");
            abort_run();
        end
    end

endmodule

/* list.f */
+incdir+source
source/cache_pkg.sv
source/set_ram.sv
source/tag_store.sv
source/data_store.sv
source/cache_fsm.sv
source/cache_top.sv
bench/cache_checker.sv
bench/cache_tb.sv

/* Makefile */
SRCS = list.f $(wildcard source/*.sv source/*.svh bench/*.sv)

all: run

obj_dir/cache_tb: $(SRCS)
	verilator --binary --timing --assert --top-module cache_tb -f list.f -Mdir obj_dir -o cache_tb

run: obj_dir/cache_tb
	obj_dir/cache_tb | tee sim.log
	grep -q "^Result: PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
